//--- source/yolo_config.svh
`ifndef YOLO_CONFIG_SVH
`define YOLO_CONFIG_SVH

// data element and accumulator widths
`define YOLO_DATA_W 16
`define YOLO_ACC_W 40

// elements per pixel word, products per mac step
`define YOLO_N_MACS 4

// neuron units and result buffers
`define YOLO_N_VECT 4

// bus word holds N_MACS elements or N_VECT results
`define YOLO_BUS_W 64
`define YOLO_ADDR_W 32

// internal buffer address widths
`define YOLO_PIX_ADDR_W 6
`define YOLO_RES_ADDR_W 6

`define YOLO_SHIFT_W 5

`endif

//--- source/yolo_pkg.sv
`default_nettype none

`include "yolo_config.svh"

package yolo_pkg;

   // one signed data element
   typedef logic signed [`YOLO_DATA_W-1:0] data_t;

   // mac accumulator, wide enough for long dot product runs
   typedef logic signed [`YOLO_ACC_W-1:0] acc_t;

   // pixel buffer word, same layout as a bus word
   typedef data_t [`YOLO_N_MACS-1:0] pixel_word_t;

   // weights for one neuron unit
   typedef data_t [`YOLO_N_MACS-1:0] weight_row_t;

endpackage

`default_nettype wire

//--- source/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module dual_port_ram
   import yolo_pkg::*;
#(
   parameter type word_t = data_t,
   parameter int ADDR_W = `YOLO_PIX_ADDR_W
) (
   input  wire               clk,
   input  wire               wr_en,
   input  wire  [ADDR_W-1:0] wr_addr,
   input  wire  word_t       wr_data,
   input  wire               rd_en,
   input  wire  [ADDR_W-1:0] rd_addr,
   output word_t             rd_data
);

   word_t mem [0:(1 << ADDR_W)-1];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read, output holds while rd_en is low
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

//--- source/pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module pixel_fetch
   import yolo_pkg::*;
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           run,
   input  wire   [`YOLO_PIX_ADDR_W:0]    count,
   input  wire   [`YOLO_ADDR_W-1:0]      base,
   output logic                          busy,
   output logic                          rd_valid,
   output logic  [`YOLO_ADDR_W-1:0]      rd_addr,
   input  wire                           rd_ready,
   input  wire   pixel_word_t            rd_data,
   output logic                          buf_wr_en,
   output logic  [`YOLO_PIX_ADDR_W-1:0]  buf_wr_addr,
   output pixel_word_t                   buf_wr_data
);

   logic [`YOLO_PIX_ADDR_W:0] count_q;
   logic [`YOLO_PIX_ADDR_W:0] idx;
   logic [`YOLO_ADDR_W-1:0]   base_q;
   logic                      xfer;

   assign rd_valid = busy;
   assign rd_addr  = base_q + `YOLO_ADDR_W'(idx);
   assign xfer     = rd_valid && rd_ready;

   // word counter, config latched on run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy    <= 1'b0;
         idx     <= '0;
         count_q <= '0;
         base_q  <= '0;
      end else if (run && !busy) begin
         busy    <= (count != '0);
         idx     <= '0;
         count_q <= count;
         base_q  <= base;
      end else if (xfer) begin
         idx <= idx + 1'b1;
         if (idx == count_q - 1'b1) begin
            busy <= 1'b0;
         end
      end
   end

   // received word goes to the pixel buffer one cycle later
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         buf_wr_en <= 1'b0;
      end else begin
         buf_wr_en <= xfer;
      end
   end

   always_ff @(posedge clk) begin
      buf_wr_addr <= idx[`YOLO_PIX_ADDR_W-1:0];
      buf_wr_data <= rd_data;
   end

   // a stalled request keeps its address until accepted
   a_rd_addr_stable: assert property (@(posedge clk) disable iff (rst)
      rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr));

endmodule

`default_nettype wire

//--- source/yolo_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module yolo_unit
   import yolo_pkg::*;
#(
   parameter int unit_index = 0
) (
   input  wire                       clk,
   input  wire                       rst,
   input  wire   pixel_word_t        pixel,
   input  wire   weight_row_t        weight,
   input  wire   data_t              bias,
   input  wire                       mac_en,
   input  wire                       ld_acc,
   input  wire                       ld_mp,
   input  wire                       ld_res,
   input  wire                       bias_en,
   input  wire                       leaky_en,
   input  wire                       maxpool_en,
   input  wire                       bypass_en,
   input  wire   [`YOLO_SHIFT_W-1:0] shift,
   output data_t                     result
);

   localparam acc_t sat_max = acc_t'((1 << (`YOLO_DATA_W - 1)) - 1);
   localparam acc_t sat_min = -sat_max - 1;

   acc_t  acc;
   acc_t  dot;
   acc_t  start_val;
   acc_t  shifted;
   acc_t  clamped;
   data_t act;
   data_t pool;
   data_t pool_next;

   // dot product of pixel word and weight row
   always_comb begin
      dot = '0;
      for (int i = 0; i < `YOLO_N_MACS; i++) begin
         dot = dot + acc_t'(pixel[i]) * acc_t'(weight[i]);
      end
   end

   assign start_val = bias_en ? acc_t'(bias) : '0;

   // shift, leaky ramp on negatives, then saturate
   always_comb begin
      shifted = acc >>> shift;
      if (leaky_en && shifted < 0) begin
         // slope of 1/8 below zero
         shifted = shifted >>> 3;
      end
      if (shifted > sat_max) begin
         clamped = sat_max;
      end else if (shifted < sat_min) begin
         clamped = sat_min;
      end else begin
         clamped = shifted;
      end
      act = clamped[`YOLO_DATA_W-1:0];
   end

   // ld_mp opens a new pooling window
   assign pool_next = (ld_mp || act > pool) ? act : pool;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc    <= '0;
         pool   <= '0;
         result <= '0;
      end else begin
         if (mac_en) begin
            acc <= (ld_acc ? start_val : acc) + dot;
         end
         if (ld_mp || (maxpool_en && ld_res)) begin
            pool <= pool_next;
         end
         if (ld_res) begin
            if (bypass_en) begin
               result <= pixel[unit_index];
            end else if (maxpool_en) begin
               result <= pool_next;
            end else begin
               result <= act;
            end
         end
      end
   end

   // restarting the accumulator is only meaningful on a mac step
   a_ld_acc_with_mac: assert property (@(posedge clk) disable iff (rst)
      ld_acc |-> mac_en);

endmodule

`default_nettype wire

//--- source/result_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module result_store
   import yolo_pkg::*;
(
   input  wire                           clk,
   input  wire                           rst,
   input  wire                           run,
   input  wire   [`YOLO_RES_ADDR_W:0]    count,
   input  wire   [`YOLO_ADDR_W-1:0]      base,
   output logic                          busy,
   output logic                          buf_rd_en,
   output logic  [`YOLO_RES_ADDR_W-1:0]  buf_rd_addr,
   input  wire   pixel_word_t            buf_rd_data,
   output logic                          wr_valid,
   output logic  [`YOLO_ADDR_W-1:0]      wr_addr,
   output pixel_word_t                   wr_data,
   input  wire                           wr_ready
);

   logic [`YOLO_RES_ADDR_W:0] count_q;
   logic [`YOLO_RES_ADDR_W:0] rd_idx;
   logic [`YOLO_RES_ADDR_W:0] wr_idx;
   logic [`YOLO_ADDR_W-1:0]   base_q;
   logic                      accept;

   assign accept = wr_valid && wr_ready;

   // read the next word when the bus slot is empty or being freed
   assign buf_rd_en   = busy && (rd_idx != count_q) && (!wr_valid || wr_ready);
   assign buf_rd_addr = rd_idx[`YOLO_RES_ADDR_W-1:0];

   // buffer output holds between reads, so it drives the bus directly
   assign wr_data = buf_rd_data;
   assign wr_addr = base_q + `YOLO_ADDR_W'(wr_idx);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy     <= 1'b0;
         wr_valid <= 1'b0;
         rd_idx   <= '0;
         wr_idx   <= '0;
         count_q  <= '0;
         base_q   <= '0;
      end else if (run && !busy) begin
         busy    <= (count != '0);
         rd_idx  <= '0;
         count_q <= count;
         base_q  <= base;
      end else if (buf_rd_en) begin
         rd_idx   <= rd_idx + 1'b1;
         wr_idx   <= rd_idx;
         wr_valid <= 1'b1;
      end else if (accept) begin
         // last word accepted, nothing left to read
         wr_valid <= 1'b0;
         busy     <= 1'b0;
      end
   end

   a_wr_stable: assert property (@(posedge clk) disable iff (rst)
      wr_valid && !wr_ready |=> wr_valid && $stable(wr_data) && $stable(wr_addr));

   // the word on the bus is the last one read, nothing further is read ahead
   a_rd_one_ahead: assert property (@(posedge clk) disable iff (rst)
      wr_valid |-> (rd_idx == wr_idx + 1'b1) && (wr_idx < count_q));

endmodule

`default_nettype wire

//--- source/yolo_write_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module yolo_write_stage
   import yolo_pkg::*;
(
   input  wire                                      clk,
   input  wire                                      rst,
   input  wire                                      run,
   output logic                                     done,
   input  wire   [`YOLO_ADDR_W-1:0]                 fetch_base,
   input  wire   [`YOLO_PIX_ADDR_W:0]               fetch_count,
   input  wire   [`YOLO_ADDR_W-1:0]                 store_base,
   input  wire   [`YOLO_RES_ADDR_W:0]               store_count,
   output logic                                     rd_valid,
   output logic  [`YOLO_ADDR_W-1:0]                 rd_addr,
   input  wire                                      rd_ready,
   input  wire   pixel_word_t                       rd_data,
   output logic                                     wr_valid,
   output logic  [`YOLO_ADDR_W-1:0]                 wr_addr,
   output pixel_word_t                              wr_data,
   input  wire                                      wr_ready,
   input  wire                                      pix_rd_en,
   input  wire   [`YOLO_PIX_ADDR_W-1:0]             pix_rd_addr,
   input  wire                                      mac_en,
   input  wire                                      ld_acc,
   input  wire                                      ld_mp,
   input  wire                                      ld_res,
   input  wire                                      bias_en,
   input  wire                                      leaky_en,
   input  wire                                      maxpool_en,
   input  wire                                      bypass_en,
   input  wire   [`YOLO_SHIFT_W-1:0]                shift,
   input  wire   weight_row_t [`YOLO_N_VECT-1:0]    weights,
   input  wire   data_t [`YOLO_N_VECT-1:0]          biases,
   input  wire   [`YOLO_N_VECT-1:0]                 res_wr_en,
   input  wire   [`YOLO_RES_ADDR_W-1:0]             res_wr_addr
);

   logic                           fetch_busy;
   logic                           store_busy;
   logic                           pix_wr_en;
   logic [`YOLO_PIX_ADDR_W-1:0]    pix_wr_addr;
   pixel_word_t                    pix_wr_data;
   pixel_word_t                    pix_rd_data;
   pixel_word_t                    pixel_q;
   logic                           res_rd_en;
   logic [`YOLO_RES_ADDR_W-1:0]    res_rd_addr;
   pixel_word_t                    res_rd_data;
   data_t [`YOLO_N_VECT-1:0]       unit_result;
   data_t [`YOLO_N_VECT-1:0]       result_q;

   assign done = !fetch_busy && !store_busy;

   pixel_fetch pixel_fetch_inst (
      .clk(clk), .rst(rst), .run(run), .count(fetch_count), .base(fetch_base),
      .busy(fetch_busy), .rd_valid(rd_valid), .rd_addr(rd_addr), .rd_ready(rd_ready),
      .rd_data(rd_data), .buf_wr_en(pix_wr_en), .buf_wr_addr(pix_wr_addr),
      .buf_wr_data(pix_wr_data)
   );

   dual_port_ram #(.word_t(pixel_word_t), .ADDR_W(`YOLO_PIX_ADDR_W)) pixel_buf_inst (
      .clk(clk), .wr_en(pix_wr_en), .wr_addr(pix_wr_addr), .wr_data(pix_wr_data),
      .rd_en(pix_rd_en), .rd_addr(pix_rd_addr), .rd_data(pix_rd_data)
   );

   // second read stage, units see the word two cycles after the request
   always_ff @(posedge clk) begin
      pixel_q <= pix_rd_data;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         result_q <= '0;
      end else begin
         result_q <= unit_result;
      end
   end

   for (genvar i = 0; i < `YOLO_N_VECT; i++) begin : g_vect
      yolo_unit #(.unit_index(i)) unit_inst (
         .clk(clk), .rst(rst), .pixel(pixel_q), .weight(weights[i]), .bias(biases[i]),
         .mac_en(mac_en), .ld_acc(ld_acc), .ld_mp(ld_mp), .ld_res(ld_res),
         .bias_en(bias_en), .leaky_en(leaky_en), .maxpool_en(maxpool_en),
         .bypass_en(bypass_en), .shift(shift), .result(unit_result[i])
      );

      // unit i lands in element i of the stored bus word
      dual_port_ram #(.word_t(data_t), .ADDR_W(`YOLO_RES_ADDR_W)) res_buf_inst (
         .clk(clk), .wr_en(res_wr_en[i]), .wr_addr(res_wr_addr), .wr_data(result_q[i]),
         .rd_en(res_rd_en), .rd_addr(res_rd_addr), .rd_data(res_rd_data[i])
      );
   end

   result_store result_store_inst (
      .clk(clk), .rst(rst), .run(run), .count(store_count), .base(store_base),
      .busy(store_busy), .buf_rd_en(res_rd_en), .buf_rd_addr(res_rd_addr),
      .buf_rd_data(res_rd_data), .wr_valid(wr_valid), .wr_addr(wr_addr),
      .wr_data(wr_data), .wr_ready(wr_ready)
   );

endmodule

`default_nettype wire

//--- tests/tb_yolo_write_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "yolo_config.svh"

module tb_yolo_write_stage
   import yolo_pkg::*;
();

   localparam int N_VECT = `YOLO_N_VECT;
   localparam int TIMEOUT = 2000;
   localparam int MODE_BYPASS = 0;
   localparam int MODE_MAC = 1;
   localparam int MODE_POOL = 2;
   localparam longint SAT_MAX = (longint'(1) << (`YOLO_DATA_W - 1)) - 1;

   logic                              clk = 1'b0;
   logic                              rst;
   logic                              run;
   logic                              done;
   logic [`YOLO_ADDR_W-1:0]           fetch_base;
   logic [`YOLO_PIX_ADDR_W:0]         fetch_count;
   logic [`YOLO_ADDR_W-1:0]           store_base;
   logic [`YOLO_RES_ADDR_W:0]         store_count;
   logic                              rd_valid;
   logic [`YOLO_ADDR_W-1:0]           rd_addr;
   logic                              rd_ready;
   pixel_word_t                       rd_data;
   logic                              wr_valid;
   logic [`YOLO_ADDR_W-1:0]           wr_addr;
   pixel_word_t                       wr_data;
   logic                              wr_ready;
   logic                              pix_rd_en;
   logic [`YOLO_PIX_ADDR_W-1:0]       pix_rd_addr;
   logic                              mac_en;
   logic                              ld_acc;
   logic                              ld_mp;
   logic                              ld_res;
   logic                              bias_en;
   logic                              leaky_en;
   logic                              maxpool_en;
   logic                              bypass_en;
   logic [`YOLO_SHIFT_W-1:0]          shift;
   weight_row_t [`YOLO_N_VECT-1:0]    weights;
   data_t [`YOLO_N_VECT-1:0]          biases;
   logic [`YOLO_N_VECT-1:0]           res_wr_en;
   logic [`YOLO_RES_ADDR_W-1:0]       res_wr_addr;

   // external memory and shadow copies of the internal buffers
   pixel_word_t ext_mem [0:255];
   pixel_word_t pix_shadow [0:63];
   pixel_word_t res_shadow [0:63];
   weight_row_t w_set [0:1][0:N_VECT-1];
   data_t       b_set [0:N_VECT-1];

   logic [31:0]             lfsr = 32'h990d_f515;
   logic                    stall_en;
   logic                    armed;
   int                      rd_seen;
   int                      wr_seen;
   int                      rd_total;
   int                      wr_total;
   logic [`YOLO_ADDR_W-1:0] cfg_fetch_base;
   logic [`YOLO_ADDR_W-1:0] cfg_store_base;
   logic                    rd_stall;
   logic                    wr_stall;
   logic [`YOLO_ADDR_W-1:0] prev_rd_addr;
   logic [`YOLO_ADDR_W-1:0] prev_wr_addr;
   pixel_word_t             prev_wr_data;

   yolo_write_stage yolo_write_stage_inst (.*);

   always #2 clk = ~clk;

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic take_bit();
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      return lfsr[0];
   endfunction

   function automatic data_t rand_elem();
      data_t v;
      v = '0;
      for (int b = 0; b < `YOLO_DATA_W; b++) begin
         v = {v[`YOLO_DATA_W-2:0], take_bit()};
      end
      return v;
   endfunction

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
         $display("ERRORS FOUND");
         $fatal(1, "stopped at first mismatch");
      end
   endtask

   // expected output of one unit over a window of pixel words
   function automatic data_t ref_result(input int unit, input int first, input int len,
                                        input int mode);
      longint start;
      longint sum;
      longint act;
      longint best;
      data_t  p;
      data_t  w;
      if (mode == MODE_BYPASS) begin
         return pix_shadow[first][unit];
      end
      start = bias_en ? longint'(biases[unit]) : 0;
      sum = start;
      best = -SAT_MAX - 2;
      for (int j = 0; j < len; j++) begin
         if (mode == MODE_POOL) begin
            sum = start;
         end
         for (int i = 0; i < `YOLO_N_MACS; i++) begin
            p = pix_shadow[first + j][i];
            w = weights[unit][i];
            sum = sum + longint'(p) * longint'(w);
         end
         if (mode == MODE_POOL || j == len - 1) begin
            act = sum >>> shift;
            if (leaky_en && act < 0) begin
               act = act >>> 3;
            end
            if (act > SAT_MAX) begin
               act = SAT_MAX;
            end else if (act < -SAT_MAX - 1) begin
               act = -SAT_MAX - 1;
            end
            if (act > best) begin
               best = act;
            end
         end
      end
      return best[`YOLO_DATA_W-1:0];
   endfunction

   // bus model and protocol checks, the only user of the lfsr after time 0
   always @(posedge clk) begin
      if (!rst) begin
         if (armed && done) begin
            check_value("reads before done", rd_seen, rd_total);
            check_value("writes before done", wr_seen, wr_total);
         end
         if (done) begin
            armed = 1'b0;
         end
         if (run) begin
            armed = 1'b1;
         end
         if (rd_stall) begin
            check_value("stalled read valid", rd_valid, 1'b1);
            check_value("stalled read address", rd_addr, prev_rd_addr);
         end
         if (wr_stall) begin
            check_value("stalled write valid", wr_valid, 1'b1);
            check_value("stalled write address", wr_addr, prev_wr_addr);
            check_value("stalled write data", wr_data, prev_wr_data);
         end
         rd_stall = rd_valid && !rd_ready;
         wr_stall = wr_valid && !wr_ready;
         prev_rd_addr = rd_addr;
         prev_wr_addr = wr_addr;
         prev_wr_data = wr_data;
         if (rd_valid && rd_ready) begin
            check_value("read address", rd_addr, cfg_fetch_base + rd_seen);
            rd_seen++;
            rd_ready <= 1'b0;
         end else if (rd_valid) begin
            // address is held from here until the transfer
            rd_data  <= ext_mem[rd_addr[7:0]];
            rd_ready <= stall_en ? take_bit() : 1'b1;
         end
         if (wr_valid && wr_ready) begin
            check_value("write address", wr_addr, cfg_store_base + wr_seen);
            check_value("write data", wr_data, res_shadow[wr_seen]);
            ext_mem[wr_addr[7:0]] = wr_data;
            wr_seen++;
         end
         wr_ready <= stall_en ? take_bit() : 1'b1;
      end
   end

   task automatic run_engines(input logic [31:0] fb, input int fc,
                              input logic [31:0] sb, input int sc);
      int waited;
      @(posedge clk);
      rd_total       = fc;
      wr_total       = sc;
      rd_seen        = 0;
      wr_seen        = 0;
      cfg_fetch_base = fb;
      cfg_store_base = sb;
      fetch_base  <= fb;
      fetch_count <= 7'(fc);
      store_base  <= sb;
      store_count <= 7'(sc);
      run         <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      @(posedge clk);
      check_value("done after run", done, fc == 0 && sc == 0);
      waited = 0;
      while (!done) begin
         if (waited == TIMEOUT) begin
            $display("timeout: engines still busy after %0d cycles", TIMEOUT);
            $display("ERRORS FOUND");
            $fatal(1, "run did not finish");
         end
         waited++;
         @(posedge clk);
      end
      check_value("read transfers", rd_seen, fc);
      check_value("write transfers", wr_seen, sc);
      for (int k = 0; k < fc; k++) begin
         pix_shadow[k] = ext_mem[8'(fb + k)];
      end
   endtask

   task automatic set_mode(input int wsel, input logic bias_on, input logic leaky_on,
                           input logic pool_on, input logic bypass_on, input int sh);
      @(posedge clk);
      for (int u = 0; u < N_VECT; u++) begin
         weights[u] <= w_set[wsel][u];
         biases[u]  <= b_set[u];
      end
      bias_en    <= bias_on;
      leaky_en   <= leaky_on;
      maxpool_en <= pool_on;
      bypass_en  <= bypass_on;
      shift      <= 5'(sh);
   endtask

   // word is in the unit pixel register after the third edge
   task automatic load_pixel(input int addr);
      @(posedge clk);
      pix_rd_en   <= 1'b1;
      pix_rd_addr <= 6'(addr);
      @(posedge clk);
      pix_rd_en <= 1'b0;
      @(posedge clk);
   endtask

   task automatic unit_step(input logic mac, input logic restart, input logic mp,
                            input logic res);
      @(posedge clk);
      mac_en <= mac;
      ld_acc <= restart;
      ld_mp  <= mp;
      ld_res <= res;
      @(posedge clk);
      mac_en <= 1'b0;
      ld_acc <= 1'b0;
      ld_mp  <= 1'b0;
      ld_res <= 1'b0;
   endtask

   task automatic compute_window(input int first, input int len, input int mode,
                                 input int dst);
      pixel_word_t exp_word;
      for (int j = 0; j < len; j++) begin
         load_pixel(first + j);
         if (mode != MODE_BYPASS) begin
            unit_step(1'b1, mode == MODE_POOL || j == 0, 1'b0, 1'b0);
         end
         if (mode == MODE_POOL) begin
            unit_step(1'b0, 1'b0, j == 0, j != 0);
         end
      end
      if (mode != MODE_POOL) begin
         unit_step(1'b0, 1'b0, 1'b0, 1'b1);
      end
      for (int u = 0; u < N_VECT; u++) begin
         exp_word[u] = ref_result(u, first, len, mode);
      end
      res_shadow[dst] = exp_word;
      // two edges after ld_res the result register holds the new value
      @(posedge clk);
      res_wr_en   <= '1;
      res_wr_addr <= 6'(dst);
      @(posedge clk);
      res_wr_en <= '0;
   endtask

   initial begin
      rst = 1'b1;
      run = 1'b0;
      fetch_base = '0;
      fetch_count = '0;
      store_base = '0;
      store_count = '0;
      rd_ready = 1'b0;
      rd_data = '0;
      wr_ready = 1'b0;
      pix_rd_en = 1'b0;
      pix_rd_addr = '0;
      mac_en = 1'b0;
      ld_acc = 1'b0;
      ld_mp = 1'b0;
      ld_res = 1'b0;
      bias_en = 1'b0;
      leaky_en = 1'b0;
      maxpool_en = 1'b0;
      bypass_en = 1'b0;
      shift = '0;
      weights = '0;
      biases = '0;
      res_wr_en = '0;
      res_wr_addr = '0;
      stall_en = 1'b0;
      armed = 1'b0;
      rd_stall = 1'b0;
      wr_stall = 1'b0;
      // block 0x20..0x2f holds non-negative pixels for the leaky case
      for (int a = 0; a < 256; a++) begin
         for (int i = 0; i < `YOLO_N_MACS; i++) begin
            ext_mem[a][i] = rand_elem();
            if (a >= 32 && a < 48) begin
               ext_mem[a][i][`YOLO_DATA_W-1] = 1'b0;
            end
         end
      end
      for (int u = 0; u < N_VECT; u++) begin
         b_set[u] = rand_elem();
         for (int i = 0; i < `YOLO_N_MACS; i++) begin
            w_set[0][u][i] = rand_elem();
            w_set[1][u][i] = rand_elem();
            w_set[1][u][i][`YOLO_DATA_W-1] = 1'b1;
         end
      end
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      check_value("done after reset", done, 1'b1);
      check_value("read valid after reset", rd_valid, 1'b0);
      check_value("write valid after reset", wr_valid, 1'b0);
      run_engines(32'h0, 0, 32'h0, 0);

      // fetch, bypass into the result buffers, store
      run_engines(32'h00, 16, 32'h0, 0);
      set_mode(0, 1'b0, 1'b0, 1'b0, 1'b1, 0);
      for (int k = 0; k < 16; k++) begin
         compute_window(k, 1, MODE_BYPASS, k);
      end
      run_engines(32'h0, 0, 32'h80, 16);

      // four-word mac windows with bias and shift
      set_mode(0, 1'b1, 1'b0, 1'b0, 1'b0, 20);
      for (int k = 0; k < 4; k++) begin
         compute_window(4 * k, 4, MODE_MAC, k);
      end
      run_engines(32'h0, 0, 32'hc0, 4);

      set_mode(0, 1'b1, 1'b0, 1'b1, 1'b0, 18);
      for (int k = 0; k < 4; k++) begin
         compute_window(4 * k, 4, MODE_POOL, k);
      end

      // random ready on both channels, fetch and store overlap
      stall_en <= 1'b1;
      run_engines(32'h20, 16, 32'hd0, 4);

      // negative weights against non-negative pixels
      set_mode(1, 1'b1, 1'b1, 1'b0, 1'b0, 16);
      for (int k = 0; k < 16; k++) begin
         compute_window(k, 1, MODE_MAC, k);
      end
      run_engines(32'h0, 0, 32'h80, 16);

      $display("NO ERRORS");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+source
source/yolo_pkg.sv
source/dual_port_ram.sv
source/pixel_fetch.sv
source/yolo_unit.sv
source/result_store.sv
source/yolo_write_stage.sv
tests/tb_yolo_write_stage.sv

//--- run_sim.sh
#!/bin/sh
# build and run the yolo write stage testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
   --top-module tb_yolo_write_stage --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^NO ERRORS$"; then
   exit 0
fi
exit 1
